// ==== Makefile ====
# Verilator build and run for rv_ctl
VERILATOR ?= verilator
TOP       ?= tb_rv_ctl
SEED      ?= 0
FILELIST  ?= rv_ctl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

VFLAGS ?= --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "no pass line"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_rv_ctl.sv ====
`timescale 1ns/1ps

module tb_rv_ctl;

  import rv_ctl_pkg::*;

  localparam int PX_ADDR_W  = 16;
  localparam int P1_EVENTS  = 60;            // run control pulses
  localparam int P2_STEPS   = 30;            // step requests
  localparam int P3_OPS     = 200;           // board csr operations
  localparam int P4_PIX     = 20;            // pixel csr writes
  localparam int P5_WORDS   = 80;            // host-link words
  localparam int MAX_CYCLES = 2 * (P1_EVENTS * 5 + P2_STEPS * 12 + P3_OPS * 2 + P4_PIX * 40 +
                                   P5_WORDS * 12 + P5_WORDS * 12);

  logic clk = 1'b0;
  logic rst_n;
  logic step_cycle, step_instr, dbg_halt_core, dbg_run_core, commit_evt, commit_ebreak;
  logic step_ack, run_cmd_val, cpu_running;
  run_mode_t run_cmd_mode;
  logic csr_valid_op, csr_commit_op;
  csr_addr_t csr_addr;
  csr_opc_t csr_opc;
  logic [XLEN-1:0] csr_wdata, csr_rdata, msec_elapsed, hlnk_in_data;
  logic csr_mem_stall, hlnk_in_valid, hlnk_in_accept;
  logic px_request, px_write;
  logic px_ready = 1'b0;
  logic [PX_ADDR_W-1:0] px_address;
  pixel_t px_write_data;
  pixel_t px_read_data = '0;
  logic [SWITCHES_W-1:0] zybo_switches;
  logic [BUTTONS_W-1:0] zybo_buttons;
  logic [LEDS_W-1:0] zybo_leds;
  logic [SSD_W-1:0] zybo_ssd;

  logic [15:0] lfsr = 16'd29951;            // galois state
  int cyc = 0;
  int mism = 0;                             // wrong values
  int other = 0;                            // protocol failures
  int drop_errs = 0;                        // counted by the responder
  int last_rdy_cyc = 0;
  pixel_t fb_mem [0:(1<<PX_ADDR_W)-1];      // frame buffer behind the port
  pixel_t exp_mem [0:(1<<PX_ADDR_W)-1];     // expected contents
  logic [PX_ADDR_W-1:0] log_addr[$];        // every fb write
  pixel_t log_data[$];
  int log_cyc[$];
  logic [PX_ADDR_W-1:0] exp_ld_addr[$];     // loader model output
  pixel_t exp_ld_data[$];
  run_mode_t exp_mode;
  logic [LEDS_W-1:0] m_leds;
  logic [SSD_W-1:0] m_ssd;
  logic [PX_ADDR_W-1:0] m_px_addr, lptr;
  pixel_t m_px_wdata, m_px_rdata;
  logic [PX_ADDR_W-1:0] wr_list[$];

  rv_ctl #(.PX_ADDR_W(PX_ADDR_W)) i_dut (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > MAX_CYCLES) begin
      $display("timeout after %0d cycles, mismatches %0d other %0d", cyc, mism, other + drop_errs);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], lfsr[0]};              // one step per bit
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic pixel_t fill_px(input int a);
    logic [31:0] h;
    h = 32'(a) * 32'h9E3779B1;
    return h[31:8];                         // all address bits reach the pixel
  endfunction

  ////////////////////////////////////////////////////////////
  // frame-buffer responder, 0..3 cycles of latency
  initial begin : responder
    int  dly;
    logic armed;
    armed = 1'b0;
    dly = 0;
    for (int j = 0; j < (1 << PX_ADDR_W); j++) fb_mem[j] = fill_px(j);
    forever begin
      @(negedge clk);
      if (px_ready) begin
        px_ready = 1'b0;
      end else if (px_request) begin
        if (!armed) begin
          armed = 1'b1;
          dly = int'(rand_bits(2));
        end
        if (dly == 0) begin
          px_ready = 1'b1;
          px_read_data = fb_mem[px_address];
          if (px_write) begin
            fb_mem[px_address] = px_write_data;
            log_addr.push_back(px_address);
            log_data.push_back(px_write_data);
            log_cyc.push_back(cyc);
          end
          last_rdy_cyc = cyc;
          armed = 1'b0;
        end else begin
          dly = dly - 1;
        end
      end else if (armed) begin
        drop_errs++;
        $display("px_request dropped before px_ready at cycle %0d", cyc);
        armed = 1'b0;
      end
    end
  end

  task automatic check_mode(input run_mode_t m, input logic val);
    if (run_cmd_mode !== m) begin
      mism++;
      $display("Mismatch run_cmd_mode got 0x%0h exp 0x%0h", run_cmd_mode, m);
    end
    if (run_cmd_val !== val) begin
      mism++;
      $display("Mismatch run_cmd_val got 0x%0h exp 0x%0h", run_cmd_val, val);
    end
    if (cpu_running !== (m == RUN_MODE)) begin
      mism++;
      $display("Mismatch cpu_running got 0x%0h exp 0x%0h", cpu_running, m == RUN_MODE);
    end
    exp_mode = m;
  endtask

  task automatic check_ack(input logic a);
    if (step_ack !== a) begin
      mism++;
      $display("Mismatch step_ack got 0x%0h exp 0x%0h", step_ack, a);
    end
  endtask

  task automatic pulse(input int which);    // 0 halt, 1 run
    dbg_halt_core = (which == 0);
    dbg_run_core  = (which == 1);
    @(negedge clk);
    dbg_halt_core = 1'b0;
    dbg_run_core  = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // run control, priority halt > ebreak > run
  task automatic run_ctl_phase();
    logic [2:0] p;
    run_mode_t  prev;
    run_mode_t  nxt;
    for (int i = 0; i < P1_EVENTS; i++) begin
      p = 3'(rand_bits(3));
      prev = exp_mode;
      dbg_halt_core = p[0];
      commit_ebreak = p[1];
      dbg_run_core  = p[2];
      nxt = (p[0] || p[1]) ? HALT_MODE : (p[2] ? RUN_MODE : prev);
      @(negedge clk);
      dbg_halt_core = 1'b0;
      commit_ebreak = 1'b0;
      dbg_run_core  = 1'b0;
      check_mode(nxt, nxt != prev);
      repeat (rand_bits(2)) begin
        @(negedge clk);
        check_mode(nxt, 1'b0);
      end
    end
    pulse(0);
    check_mode(HALT_MODE, exp_mode != HALT_MODE);
  endtask

  task automatic step_release();
    repeat (rand_bits(2)) begin             // requester holds a while
      @(negedge clk);
      check_ack(1'b1);
      check_mode(HALT_MODE, 1'b0);
    end
    step_cycle = 1'b0;
    step_instr = 1'b0;
    @(negedge clk);
    check_ack(1'b0);
  endtask

  task automatic step_phase();
    logic [1:0] k;
    for (int i = 0; i < P2_STEPS; i++) begin
      k = 2'(rand_bits(2));
      if (k == 2'd3) begin                  // edge while running is ignored
        pulse(1);
        check_mode(RUN_MODE, 1'b1);
        step_cycle = rand_bits(1) != 0;
        step_instr = !step_cycle;
        @(negedge clk);
        check_mode(RUN_MODE, 1'b0);
        check_ack(1'b0);
        step_cycle = 1'b0;
        step_instr = 1'b0;
        pulse(0);
        check_mode(HALT_MODE, 1'b1);
      end else if (k[0]) begin
        step_cycle = 1'b1;
        @(negedge clk);
        check_mode(STEP_CYCLE_MODE, 1'b1);
        check_ack(1'b0);
        @(negedge clk);
        check_mode(HALT_MODE, 1'b1);
        check_ack(1'b1);
        step_release();
      end else begin
        step_instr = 1'b1;
        @(negedge clk);
        check_mode(STEP_INST_MODE, 1'b1);
        repeat (rand_bits(2)) begin
          @(negedge clk);
          check_mode(STEP_INST_MODE, 1'b0);
          check_ack(1'b0);
        end
        commit_evt = 1'b1;
        @(negedge clk);
        commit_evt = 1'b0;
        check_mode(HALT_MODE, 1'b1);
        check_ack(1'b1);
        step_release();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // csr model
  function automatic logic [31:0] csr_model(input csr_addr_t a);
    case (a)
      CSR_LEDS:     return 32'(m_leds);
      CSR_SSD:      return 32'(m_ssd);
      CSR_SWITCHES: return 32'(zybo_switches);
      CSR_BUTTONS:  return 32'(zybo_buttons);
      CSR_MSEC:     return msec_elapsed;
      CSR_PX_ADDR:  return 32'(m_px_addr);
      CSR_PX_WDATA: return 32'(m_px_wdata);
      CSR_PX_RDATA: return 32'(m_px_rdata);
      default:      return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] csr_update(input logic [1:0] op, input logic [31:0] old_v,
                                             input logic [31:0] src);
    if (op == 2'd1) return src;
    if (op == 2'd2) return old_v | src;
    if (op == 2'd3) return old_v & ~src;
    return old_v;
  endfunction

  task automatic csr_commit(input csr_addr_t a, input csr_opc_t o, input logic [31:0] d,
                            input logic stall_timing);
    logic [31:0] old_v;
    logic [31:0] new_v;
    logic        px_op;
    old_v = csr_model(a);
    px_op = ((a == CSR_PX_WDATA) && (o[1:0] != 2'd0)) || (a == CSR_PX_RDATA);
    csr_addr = a;
    csr_opc = o;
    csr_wdata = d;
    csr_valid_op = 1'b1;
    csr_commit_op = 1'b1;
    #2;                                      // read mux settles
    if (csr_rdata !== old_v) begin
      mism++;
      $display("Mismatch csr_rdata got 0x%0h exp 0x%0h at 0x%0h", csr_rdata, old_v, a);
    end
    if (csr_mem_stall !== px_op) begin
      mism++;
      $display("Mismatch csr_mem_stall got 0x%0h exp 0x%0h", csr_mem_stall, px_op);
    end
    new_v = csr_update(o[1:0], old_v, d);
    case (a)
      CSR_LEDS:     m_leds = new_v[LEDS_W-1:0];
      CSR_SSD:      m_ssd = new_v[SSD_W-1:0];
      CSR_PX_ADDR:  m_px_addr = new_v[PX_ADDR_W-1:0];
      CSR_PX_WDATA: m_px_wdata = new_v[PIXEL_W-1:0];
      default: ;
    endcase
    if (px_op && (a == CSR_PX_WDATA)) exp_mem[m_px_addr] = m_px_wdata;
    @(negedge clk);
    csr_valid_op = 1'b0;
    csr_commit_op = 1'b0;
    while (csr_mem_stall) @(negedge clk);   // stalled until the buffer answers
    if (px_op) begin
      if (stall_timing && (cyc != last_rdy_cyc + 1)) begin
        other++;
        $display("csr_mem_stall did not fall one cycle after px_ready");
      end
      if (a == CSR_PX_RDATA) m_px_rdata = exp_mem[m_px_addr];
    end
    if (zybo_leds !== m_leds) begin
      mism++;
      $display("Mismatch zybo_leds got 0x%0h exp 0x%0h", zybo_leds, m_leds);
    end
    if (zybo_ssd !== m_ssd) begin
      mism++;
      $display("Mismatch zybo_ssd got 0x%0h exp 0x%0h", zybo_ssd, m_ssd);
    end
  endtask

  task automatic board_csr_phase();
    csr_addr_t a;
    logic [2:0] idx;
    for (int i = 0; i < P3_OPS; i++) begin
      zybo_switches = SWITCHES_W'(rand_bits(SWITCHES_W));
      zybo_buttons = BUTTONS_W'(rand_bits(BUTTONS_W));
      msec_elapsed = rand_bits(32);
      idx = 3'(rand_bits(3));
      case (idx)
        3'd0: a = CSR_LEDS;
        3'd1: a = CSR_SSD;
        3'd2: a = CSR_SWITCHES;
        3'd3: a = CSR_BUTTONS;
        3'd4: a = CSR_MSEC;
        3'd5: a = CSR_PX_ADDR;
        3'd6: a = 12'hBCB;                  // hole in the board map
        default: a = 12'(rand_bits(8));     // far outside the map
      endcase
      csr_commit(a, csr_opc_t'(rand_bits(3)), rand_bits(32), 1'b0);
    end
  endtask

  task automatic pixel_csr_phase(input int n, input logic readback, input logic timing);
    logic [1:0] t;
    for (int i = 0; i < n; i++) begin
      csr_commit(CSR_PX_ADDR, 3'd1, rand_bits(14), 1'b0);   // low quarter only
      wr_list.push_back(m_px_addr);
      t = 2'(rand_bits(2));
      if (t == 2'd0) t = 2'd1;
      csr_commit(CSR_PX_WDATA, {rand_bits(1) != 0, t}, rand_bits(32), timing);
    end
    while (readback && wr_list.size() > 0) begin
      csr_commit(CSR_PX_ADDR, 3'd1, 32'(wr_list.pop_front()), 1'b0);
      csr_commit(CSR_PX_RDATA, csr_opc_t'(rand_bits(3)), rand_bits(32), timing);
      csr_commit(CSR_PX_RDATA, 3'd0, 32'h0, timing);        // rdata shows the fetch
    end
    wr_list.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // host-link stream with loader model
  task automatic hlink_stream(input int n);
    logic [31:0] w;
    for (int i = 0; i < n; i++) begin
      repeat (rand_bits(2)) @(negedge clk);
      if (i == 0 || rand_bits(3) == 0) begin
        lptr = 16'h8000 | 16'(rand_bits(14));              // upper half only
        w = {1'b1, 15'(rand_bits(15)), lptr};
      end else begin
        w = {1'b0, 31'(rand_bits(31))};
        exp_ld_addr.push_back(lptr);
        exp_ld_data.push_back(w[PIXEL_W-1:0]);
        exp_mem[lptr] = w[PIXEL_W-1:0];
        lptr = lptr + 16'd1;
      end
      hlnk_in_data = w;
      hlnk_in_valid = 1'b1;
      while (!hlnk_in_accept) @(negedge clk);
      @(negedge clk);
      hlnk_in_valid = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < 3) begin
      @(negedge clk);
      quiet = (!px_request && hlnk_in_accept && !csr_mem_stall) ? quiet + 1 : 0;
    end
  endtask

  initial begin : stimulus
    int first;
    rst_n = 1'b0;
    {step_cycle, step_instr, dbg_halt_core, dbg_run_core, commit_evt, commit_ebreak} = '0;
    {csr_valid_op, csr_commit_op, hlnk_in_valid} = '0;
    csr_addr = '0;
    csr_opc = '0;
    csr_wdata = '0;
    hlnk_in_data = '0;
    msec_elapsed = '0;
    zybo_switches = '0;
    zybo_buttons = '0;
    {m_leds, m_ssd, m_px_addr, m_px_wdata, m_px_rdata, lptr} = '0;
    exp_mode = HALT_MODE;
    for (int j = 0; j < (1 << PX_ADDR_W); j++) exp_mem[j] = fill_px(j);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_mode(HALT_MODE, 1'b0);
    check_ack(1'b0);
    if (csr_mem_stall !== 1'b0 || px_request !== 1'b0 || hlnk_in_accept !== 1'b1) begin
      other++;
      $display("stall, px_request or hlnk_in_accept wrong after reset");
    end

    run_ctl_phase();
    step_phase();
    board_csr_phase();
    pixel_csr_phase(P4_PIX, 1'b1, 1'b1);

    first = log_addr.size();                // loader alone on the port
    hlink_stream(P5_WORDS);
    wait_idle();
    if (log_addr.size() - first != exp_ld_addr.size()) begin
      other++;
      $display("loader made %0d writes, expected %0d", log_addr.size() - first,
               exp_ld_addr.size());
    end
    for (int i = 0; i < exp_ld_addr.size() && first + i < log_addr.size(); i++) begin
      if (log_addr[first + i] !== exp_ld_addr[i] || log_data[first + i] !== exp_ld_data[i]) begin
        mism++;
        $display("Mismatch px_address/px_write_data got 0x%0h/0x%0h exp 0x%0h/0x%0h cyc %0d",
                 log_addr[first + i], log_data[first + i], exp_ld_addr[i], exp_ld_data[i],
                 log_cyc[first + i]);
      end
    end

    fork                                    // both requesters at once
      hlink_stream(P5_WORDS);
      pixel_csr_phase(P5_WORDS / 4, 1'b0, 1'b0);
    join
    wait_idle();
    for (int j = 0; j < (1 << PX_ADDR_W); j++) begin
      if (fb_mem[j] !== exp_mem[j]) begin
        mism++;
        $display("Mismatch fb_mem[0x%0h] got 0x%0h exp 0x%0h", j, fb_mem[j], exp_mem[j]);
      end
    end

    $display("mismatches %0d other errors %0d", mism, other + drop_errs);
    if (mism == 0 && other + drop_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps

module csr_file #(
  parameter int PX_ADDR_W = 16                               // pixel address width
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 csr_valid_op,  // read phase
  input  logic                                 csr_commit_op, // update phase
  input  rv_ctl_pkg::csr_addr_t                csr_addr,
  input  rv_ctl_pkg::csr_opc_t                 csr_opc,
  input  logic [rv_ctl_pkg::XLEN-1:0]          csr_wdata,
  output logic [rv_ctl_pkg::XLEN-1:0]          csr_rdata,     // old value of the csr
  output logic                                 csr_mem_stall, // fb access in flight
  input  logic [rv_ctl_pkg::SWITCHES_W-1:0]    zybo_switches,
  input  logic [rv_ctl_pkg::BUTTONS_W-1:0]     zybo_buttons,
  input  logic [rv_ctl_pkg::XLEN-1:0]          msec_elapsed,
  output logic [rv_ctl_pkg::LEDS_W-1:0]        zybo_leds,
  output logic [rv_ctl_pkg::SSD_W-1:0]         zybo_ssd,
  output logic                                 fb_req,        // pixel csr requester
  output logic                                 fb_we,
  output logic [PX_ADDR_W-1:0]                 fb_addr,
  output rv_ctl_pkg::pixel_t                   fb_wdata,
  input  logic                                 fb_ready,
  input  rv_ctl_pkg::pixel_t                   fb_rdata
);

  import rv_ctl_pkg::*;

  logic [LEDS_W-1:0]    leds_q;
  logic [SSD_W-1:0]     ssd_q;
  logic [PX_ADDR_W-1:0] px_addr_q;
  pixel_t               px_wdata_q;
  pixel_t               px_rdata_q;  // last pixel fetched from fb
  logic [XLEN-1:0]      rd_val;      // selected csr, zero extended
  logic [XLEN-1:0]      wr_val;      // value after rw/rs/rc
  logic                 wr_class;    // opcode modifies its csr
  logic                 px_start;    // this commit needs the frame buffer

  function automatic logic [XLEN-1:0] csr_apply(
    input logic [1:0]      op,
    input logic [XLEN-1:0] old_val,
    input logic [XLEN-1:0] src
  );
    case (op)
      CSR_OP_WRITE: return src;
      CSR_OP_SET:   return old_val | src;
      CSR_OP_CLEAR: return old_val & ~src;
      default:      return old_val;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // read side
  always_comb begin
    case (csr_addr)
      CSR_LEDS:     rd_val = XLEN'(leds_q);
      CSR_SSD:      rd_val = XLEN'(ssd_q);
      CSR_SWITCHES: rd_val = XLEN'(zybo_switches);
      CSR_BUTTONS:  rd_val = XLEN'(zybo_buttons);
      CSR_MSEC:     rd_val = msec_elapsed;
      CSR_PX_ADDR:  rd_val = XLEN'(px_addr_q);
      CSR_PX_WDATA: rd_val = XLEN'(px_wdata_q);
      CSR_PX_RDATA: rd_val = XLEN'(px_rdata_q);
      default:      rd_val = '0;                      // unmapped reads as zero
    endcase
  end

  assign csr_rdata = csr_valid_op ? rd_val : '0;
  assign wr_val    = csr_apply(csr_opc[1:0], rd_val, csr_wdata); // imm forms share op
  assign wr_class  = (csr_opc[1:0] != CSR_OP_NONE);
  assign px_start  = csr_commit_op &&
                     (((csr_addr == CSR_PX_WDATA) && wr_class) || (csr_addr == CSR_PX_RDATA));

  ////////////////////////////////////////////////////////////
  // write side, read-only and unmapped addresses fall through
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      leds_q     <= '0;
      ssd_q      <= '0;
      px_addr_q  <= '0;
      px_wdata_q <= '0;
      px_rdata_q <= '0;
    end else begin
      if (csr_commit_op) begin
        case (csr_addr)
          CSR_LEDS:     leds_q     <= wr_val[LEDS_W-1:0];
          CSR_SSD:      ssd_q      <= wr_val[SSD_W-1:0];
          CSR_PX_ADDR:  px_addr_q  <= wr_val[PX_ADDR_W-1:0];
          CSR_PX_WDATA: px_wdata_q <= wr_val[PIXEL_W-1:0]; // goes out with fb_req
          default: ;
        endcase
      end
      if (fb_req && fb_ready && !fb_we) px_rdata_q <= fb_rdata; // capture read pixel
    end
  end

  assign zybo_leds = leds_q;
  assign zybo_ssd  = ssd_q;

  ////////////////////////////////////////////////////////////
  // frame-buffer request, held until ready
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fb_req <= 1'b0;
      fb_we  <= 1'b0;
    end else if (fb_req) begin
      if (fb_ready) fb_req <= 1'b0;                      // drop the cycle after ready
    end else if (px_start) begin
      fb_req <= 1'b1;
      fb_we  <= (csr_addr == CSR_PX_WDATA);
    end
  end

  assign fb_addr       = px_addr_q;
  assign fb_wdata      = px_wdata_q;
  assign csr_mem_stall = fb_req || px_start;             // up from the commit cycle

  a_no_commit_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    fb_req |-> !csr_commit_op)
    else $error("csr commit while the pixel access is stalled");

endmodule

// ==== rtl/hlnk_px_loader.sv ====
`timescale 1ns/1ps

module hlnk_px_loader #(
  parameter int PX_ADDR_W = 16                         // pixel address width
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        hlnk_in_valid,   // host word offered
  input  logic [rv_ctl_pkg::XLEN-1:0] hlnk_in_data,
  output logic                        hlnk_in_accept,  // low while a write pends
  output logic                        ld_req,          // fb write request
  output logic [PX_ADDR_W-1:0]        ld_addr,
  output rv_ctl_pkg::pixel_t          ld_wdata,
  input  logic                        ld_ready
);

  import rv_ctl_pkg::*;

  logic [PX_ADDR_W-1:0] ptr;       // next pixel to write
  logic                 is_ptr;    // bit 31 marks a pointer word
  logic                 take;      // word moves this cycle

  assign is_ptr         = hlnk_in_data[XLEN-1];
  assign hlnk_in_accept = ~ld_req;
  assign take           = hlnk_in_valid && hlnk_in_accept;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ld_req <= 1'b0;
      ptr    <= '0;
    end else if (ld_req) begin
      if (ld_ready) begin
        ld_req <= 1'b0;
        ptr    <= ptr + 1'b1;               // wraps at the top of the buffer
      end
    end else if (take) begin
      if (is_ptr) ptr <= hlnk_in_data[PX_ADDR_W-1:0];
      else ld_req <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (take && !is_ptr) ld_wdata <= hlnk_in_data[PIXEL_W-1:0]; // held while pending
  end

  assign ld_addr = ptr;

endmodule

// ==== rtl/px_arbiter.sv ====
`timescale 1ns/1ps

module px_arbiter #(
  parameter int PX_ADDR_W = 16                 // pixel address width
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 c_req,          // csr side, read or write
  input  logic                 c_we,
  input  logic [PX_ADDR_W-1:0] c_addr,
  input  rv_ctl_pkg::pixel_t   c_wdata,
  output logic                 c_ready,
  output rv_ctl_pkg::pixel_t   c_rdata,
  input  logic                 l_req,          // loader side, write only
  input  logic [PX_ADDR_W-1:0] l_addr,
  input  rv_ctl_pkg::pixel_t   l_wdata,
  output logic                 l_ready,
  output logic                 px_request,     // frame-buffer port
  output logic                 px_write,
  output logic [PX_ADDR_W-1:0] px_address,
  output rv_ctl_pkg::pixel_t   px_write_data,
  input  logic                 px_ready,
  input  rv_ctl_pkg::pixel_t   px_read_data
);

  import rv_ctl_pkg::*;

  logic busy;       // grant outstanding
  logic owner;      // 0 csr, 1 loader
  logic prio;       // side favoured on a tie
  logic pick;       // winner this cycle

  assign pick = (c_req && l_req) ? prio : l_req;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      owner <= 1'b0;
      prio  <= 1'b0;
    end else if (busy) begin
      if (px_ready) busy <= 1'b0;       // owner drops req on the same edge
    end else if (c_req || l_req) begin
      busy  <= 1'b1;
      owner <= pick;
      prio  <= ~pick;                   // other side wins the next tie
    end
  end

  ////////////////////////////////////////////////////////////
  // route the owner out, ready back to the owner only
  assign px_request    = busy;
  assign px_write      = owner ? 1'b1 : c_we;
  assign px_address    = owner ? l_addr : c_addr;
  assign px_write_data = owner ? l_wdata : c_wdata;
  assign c_ready       = busy && px_ready && !owner;
  assign l_ready       = busy && px_ready && owner;
  assign c_rdata       = px_read_data;

  a_px_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (px_request && !px_ready) |=> (px_request && $stable(px_write) &&
                                   $stable(px_address) && $stable(px_write_data)))
    else $error("fb request changed before ready");

  a_ready_to_requester: assert property (@(posedge clk) disable iff (!rst_n)
    (c_ready -> c_req) && (l_ready -> l_req))
    else $error("ready returned to a side without a request");

endmodule

// ==== rtl/run_ctrl.sv ====
`timescale 1ns/1ps

module run_ctrl (
  input  logic                  clk,           // core clock
  input  logic                  rst_n,         // sync, active low
  input  logic                  step_cycle,    // 0->1 asks for a cycle step
  input  logic                  step_instr,    // 0->1 asks for an instruction step
  input  logic                  dbg_halt_core, // 1-cycle halt pulse
  input  logic                  dbg_run_core,  // 1-cycle run pulse
  input  logic                  commit_evt,    // something committed at mem
  input  logic                  commit_ebreak, // ebreak committed
  output logic                  step_ack,      // four-phase step acknowledge
  output logic                  run_cmd_val,   // run_cmd_mode just changed
  output logic                  cpu_running,   // 1 only in free run
  output rv_ctl_pkg::run_mode_t run_cmd_mode   // current run mode
);

  import rv_ctl_pkg::*;

  logic      step_cycle_q;  // previous sample for edge detect
  logic      step_instr_q;
  logic      cyc_edge;      // rising edge on step_cycle
  logic      ins_edge;      // rising edge on step_instr
  logic      in_step;       // a step mode is active
  logic      step_done;     // leaving a step mode for halt
  run_mode_t mode_nxt;

  assign cyc_edge = step_cycle & ~step_cycle_q;
  assign ins_edge = step_instr & ~step_instr_q;
  assign in_step  = (run_cmd_mode == STEP_CYCLE_MODE) || (run_cmd_mode == STEP_INST_MODE);

  ////////////////////////////////////////////////////////////
  // next mode, debugger halt beats ebreak beats run
  always_comb begin
    mode_nxt = run_cmd_mode;
    if (dbg_halt_core || commit_ebreak) begin
      mode_nxt = HALT_MODE;
    end else if (dbg_run_core) begin
      mode_nxt = RUN_MODE;
    end else begin
      case (run_cmd_mode)
        HALT_MODE: begin                           // step edges only count while halted
          if (cyc_edge) mode_nxt = STEP_CYCLE_MODE;
          else if (ins_edge) mode_nxt = STEP_INST_MODE;
        end
        STEP_CYCLE_MODE: mode_nxt = HALT_MODE;     // single clock of progress
        STEP_INST_MODE: begin
          if (commit_evt) mode_nxt = HALT_MODE;    // stop once one instr commits
        end
        default: ;
      endcase
    end
  end

  assign step_done   = in_step && (mode_nxt == HALT_MODE); // also covers halt mid-step
  assign cpu_running = (run_cmd_mode == RUN_MODE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_cmd_mode <= HALT_MODE;
      run_cmd_val  <= 1'b0;
      step_ack     <= 1'b0;
      step_cycle_q <= 1'b0;
      step_instr_q <= 1'b0;
    end else begin
      step_cycle_q <= step_cycle;
      step_instr_q <= step_instr;
      run_cmd_mode <= mode_nxt;
      run_cmd_val  <= (mode_nxt != run_cmd_mode); // flag every real mode change
      if (step_done) begin
        step_ack <= 1'b1;                         // ack with the return to halt
      end else if (!step_cycle && !step_instr) begin
        step_ack <= 1'b0;                         // request withdrawn, close handshake
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  a_ack_after_step: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(step_ack) |-> $past(in_step && (step_cycle || step_instr)))
    else $error("step_ack rose without a step request in progress");

  a_val_on_change: assert property (@(posedge clk) disable iff (!rst_n)
    run_cmd_val |-> $past(dbg_halt_core || dbg_run_core || commit_ebreak || in_step ||
                          ((run_cmd_mode == HALT_MODE) && (cyc_edge || ins_edge))))
    else $error("run_cmd_val without a command, an ebreak or a step");

endmodule

// ==== rtl/rv_ctl.sv ====
`timescale 1ns/1ps

module rv_ctl #(
  parameter int PX_ADDR_W = 16                                  // pixel address width
) (
  input  logic                              clk,
  input  logic                              rst_n,
  // run control
  input  logic                              step_cycle,
  input  logic                              step_instr,
  output logic                              step_ack,
  input  logic                              dbg_halt_core,
  input  logic                              dbg_run_core,
  output rv_ctl_pkg::run_mode_t             run_cmd_mode,
  output logic                              run_cmd_val,
  output logic                              cpu_running,
  // pipeline side
  input  logic                              commit_evt,
  input  logic                              commit_ebreak,
  input  logic                              csr_valid_op,
  input  logic                              csr_commit_op,
  input  rv_ctl_pkg::csr_addr_t             csr_addr,
  input  rv_ctl_pkg::csr_opc_t              csr_opc,
  input  logic [rv_ctl_pkg::XLEN-1:0]       csr_wdata,
  output logic [rv_ctl_pkg::XLEN-1:0]       csr_rdata,
  output logic                              csr_mem_stall,
  // host link input channel
  input  logic                              hlnk_in_valid,
  input  logic [rv_ctl_pkg::XLEN-1:0]       hlnk_in_data,
  output logic                              hlnk_in_accept,
  // frame buffer
  output logic                              px_request,
  output logic                              px_write,
  output logic [PX_ADDR_W-1:0]              px_address,
  output rv_ctl_pkg::pixel_t                px_write_data,
  input  logic                              px_ready,
  input  rv_ctl_pkg::pixel_t                px_read_data,
  // board io
  input  logic [rv_ctl_pkg::XLEN-1:0]       msec_elapsed,
  input  logic [rv_ctl_pkg::SWITCHES_W-1:0] zybo_switches,
  input  logic [rv_ctl_pkg::BUTTONS_W-1:0]  zybo_buttons,
  output logic [rv_ctl_pkg::LEDS_W-1:0]     zybo_leds,
  output logic [rv_ctl_pkg::SSD_W-1:0]      zybo_ssd
);

  import rv_ctl_pkg::*;

  logic                 fb_req;     // csr pixel requester
  logic                 fb_we;
  logic [PX_ADDR_W-1:0] fb_addr;
  pixel_t               fb_wdata;
  logic                 fb_ready;
  pixel_t               fb_rdata;
  logic                 ld_req;     // host-link pixel loader
  logic [PX_ADDR_W-1:0] ld_addr;
  pixel_t               ld_wdata;
  logic                 ld_ready;

  run_ctrl i_run_ctrl (.*);

  csr_file #(.PX_ADDR_W(PX_ADDR_W)) i_csr_file (.*);

  hlnk_px_loader #(.PX_ADDR_W(PX_ADDR_W)) i_hlnk_px_loader (.*);

  ////////////////////////////////////////////////////////////
  // one frame-buffer port, two requesters
  px_arbiter #(.PX_ADDR_W(PX_ADDR_W)) i_px_arbiter (
    .clk           (clk          ),
    .rst_n         (rst_n        ),
    .c_req         (fb_req       ), // csr side
    .c_we          (fb_we        ),
    .c_addr        (fb_addr      ),
    .c_wdata       (fb_wdata     ),
    .c_ready       (fb_ready     ),
    .c_rdata       (fb_rdata     ),
    .l_req         (ld_req       ), // loader side
    .l_addr        (ld_addr      ),
    .l_wdata       (ld_wdata     ),
    .l_ready       (ld_ready     ),
    .px_request    (px_request   ),
    .px_write      (px_write     ),
    .px_address    (px_address   ),
    .px_write_data (px_write_data),
    .px_ready      (px_ready     ),
    .px_read_data  (px_read_data )
  );

endmodule

// ==== rtl/rv_ctl_pkg.sv ====
package rv_ctl_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  localparam int XLEN       = 32;             // data word width
  localparam int PIXEL_W    = 24;             // rgb pixel, 8 bits per channel
  localparam int LEDS_W     = 4;              // board leds
  localparam int SSD_W      = 8;              // seven-segment pmod
  localparam int SWITCHES_W = 2;              // slide switches
  localparam int BUTTONS_W  = 3;              // push buttons 3..1

  typedef logic [PIXEL_W-1:0] pixel_t;        // one frame-buffer pixel
  typedef logic [11:0]        csr_addr_t;     // csr number from the instruction
  typedef logic [2:0]         csr_opc_t;      // funct3, bit 2 only marks the imm form

  ////////////////////////////////////////////////////////////
  // run modes
  typedef enum logic [1:0] {
    HALT_MODE       = 2'd0,                   // core stopped
    RUN_MODE        = 2'd1,                   // free running
    STEP_CYCLE_MODE = 2'd2,                   // one clock then halt
    STEP_INST_MODE  = 2'd3                    // until next commit then halt
  } run_mode_t;

  ////////////////////////////////////////////////////////////
  // csr operations, low two bits of csr_opc_t
  localparam logic [1:0] CSR_OP_NONE  = 2'd0; // leaves the csr alone
  localparam logic [1:0] CSR_OP_WRITE = 2'd1; // csrrw / csrrwi
  localparam logic [1:0] CSR_OP_SET   = 2'd2; // csrrs / csrrsi
  localparam logic [1:0] CSR_OP_CLEAR = 2'd3; // csrrc / csrrci

  // board csr map, machine custom read/write space
  localparam csr_addr_t CSR_LEDS     = 12'hBC0; // rw, 4 bits
  localparam csr_addr_t CSR_SSD      = 12'hBC1; // rw, 8 bits
  localparam csr_addr_t CSR_SWITCHES = 12'hBC2; // ro, 2 bits
  localparam csr_addr_t CSR_BUTTONS  = 12'hBC3; // ro, 3 bits
  localparam csr_addr_t CSR_MSEC     = 12'hBC4; // ro, ms since reset
  localparam csr_addr_t CSR_PX_ADDR  = 12'hBC8; // rw, pixel index
  localparam csr_addr_t CSR_PX_WDATA = 12'hBC9; // write starts a fb write
  localparam csr_addr_t CSR_PX_RDATA = 12'hBCA; // commit starts a fb read

endpackage

// ==== rv_ctl.f ====
rtl/rv_ctl_pkg.sv
rtl/run_ctrl.sv
rtl/csr_file.sv
rtl/hlnk_px_loader.sv
rtl/px_arbiter.sv
rtl/rv_ctl.sv
bench/tb_rv_ctl.sv
